/* Makefile */
TOP = tb_audio_core

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* audio_core_top.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module audio_core_top (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_record,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    input  logic                    i_fast,
    input  logic [`AUD_SPEED_W-1:0] i_speed,
    input  logic                    i_interpolation,
    input  logic                    i_bclk,
    input  logic                    i_lrck,
    input  logic                    i_adc_dat,
    output logic                    o_dac_dat,
    output logic                    o_recording,
    output logic                    o_playing
);

    logic               wr_req;
    mem_pkg::ram_addr_t wr_addr;
    audio_pkg::sample_t wr_data;
    logic               wr_gnt;
    logic               rd_req;
    mem_pkg::ram_addr_t rd_addr;
    logic               rd_gnt;
    logic               rd_valid;
    audio_pkg::sample_t rd_data;
    mem_pkg::ram_addr_t end_addr;
    logic               smp_valid;
    audio_pkg::sample_t smp_data;
    logic               credit;

    audio_recorder u_recorder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_record    (i_record),
        .i_stop      (i_stop),
        .i_bclk      (i_bclk),
        .i_lrck      (i_lrck),
        .i_adc_dat   (i_adc_dat),
        .o_wr_req    (wr_req),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .i_wr_gnt    (wr_gnt),
        .o_end_addr  (end_addr),
        .o_recording (o_recording)
    );

    audio_player u_player (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_speed         (i_speed),
        .i_interpolation (i_interpolation),
        .i_end_addr      (end_addr),
        .i_recording     (o_recording),  // no playback while recording
        .o_rd_req        (rd_req),
        .o_rd_addr       (rd_addr),
        .i_rd_gnt        (rd_gnt),
        .i_rd_valid      (rd_valid),
        .i_rd_data       (rd_data),
        .o_smp_valid     (smp_valid),
        .o_smp_data      (smp_data),
        .i_credit        (credit),
        .o_playing       (o_playing)
    );

    sample_ram_arbiter u_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_req   (wr_req),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_wr_gnt   (wr_gnt),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_gnt   (rd_gnt),
        .o_rd_valid (rd_valid),
        .o_rd_data  (rd_data)
    );

    dac_serializer u_serializer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_smp_valid (smp_valid),
        .i_smp_data  (smp_data),
        .o_credit    (credit),
        .i_bclk      (i_bclk),
        .i_lrck      (i_lrck),
        .o_dac_dat   (o_dac_dat)
    );

endmodule

/* audio_defines.svh */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

`define AUD_SAMPLE_W    16  // bits per sample
`define AUD_ADDR_W      6
`define AUD_RAM_DEPTH   64
`define AUD_SPEED_W     4
`define AUD_DAC_CREDITS 2   // dac buffer entries

`endif

/* audio_pkg.sv */
`include "audio_defines.svh"

package audio_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;  // unsigned pcm

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAY,
        ST_PAUSE,
        ST_BACKTRACK  // fast + interpolation selects reverse
    } play_state_e;

endpackage

/* audio_player.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module audio_player (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    input  logic                    i_fast,           // 1 fast, 0 slow
    input  logic [`AUD_SPEED_W-1:0] i_speed,
    input  logic                    i_interpolation,  // 1 linear, 0 constant
    input  mem_pkg::ram_addr_t      i_end_addr,
    input  logic                    i_recording,
    output logic                    o_rd_req,
    output mem_pkg::ram_addr_t      o_rd_addr,
    input  logic                    i_rd_gnt,
    input  logic                    i_rd_valid,
    input  audio_pkg::sample_t      i_rd_data,
    output logic                    o_smp_valid,
    output audio_pkg::sample_t      o_smp_data,
    input  logic                    i_credit,
    output logic                    o_playing
);

    localparam int CRED_W = $clog2(`AUD_DAC_CREDITS + 1);
    localparam int EXT_W  = `AUD_ADDR_W + 1;

    audio_pkg::play_state_e                state;
    mem_pkg::ram_addr_t                    addr;
    logic                                  addr_ok;  // addr still inside the recording
    logic                                  prime;    // first fetch only loads prev
    logic [`AUD_SPEED_W-1:0]               phase;
    logic [CRED_W-1:0]                     credits;
    audio_pkg::sample_t                    prev;
    audio_pkg::sample_t                    cur;
    audio_pkg::sample_t                    out;
    logic [`AUD_SAMPLE_W+`AUD_SPEED_W-1:0] lin_sum;
    logic [EXT_W-1:0]                      nxt;
    logic                                  nxt_ok;
    logic                                  back_mode;
    logic                                  backward;
    logic                                  running;
    logic                                  busy;
    logic                                  has_credit;
    logic                                  ctrl;
    logic                                  step;
    logic                                  adv;
    logic                                  push;

    // v / s through a reciprocal table
    function automatic audio_pkg::sample_t frac_mul(input audio_pkg::sample_t v,
                                                    input logic [`AUD_SPEED_W-1:0] s);
        logic [`AUD_SAMPLE_W-1:0]   recip;
        logic [2*`AUD_SAMPLE_W-1:0] prod;
        case (s)
            4'd2:    recip = 16'h8000;
            4'd3:    recip = 16'h5555;
            4'd4:    recip = 16'h4000;
            4'd5:    recip = 16'h3333;
            4'd6:    recip = 16'h2AAA;
            4'd7:    recip = 16'h2492;
            4'd8:    recip = 16'h2000;
            4'd9:    recip = 16'h1C71;
            4'd10:   recip = 16'h1999;
            4'd11:   recip = 16'h1745;
            4'd12:   recip = 16'h1555;
            4'd13:   recip = 16'h13B1;
            4'd14:   recip = 16'h1249;
            4'd15:   recip = 16'h1111;
            default: recip = '0;
        endcase
        prod = v * recip;
        return (s == 1) ? v : prod[2*`AUD_SAMPLE_W-1:`AUD_SAMPLE_W];
    endfunction

    assign back_mode  = i_fast && i_interpolation;
    assign backward   = (state == audio_pkg::ST_BACKTRACK);
    assign running    = backward || (state == audio_pkg::ST_PLAY);
    assign busy       = o_rd_req || i_rd_valid;  // one read in flight
    assign has_credit = (credits != '0);
    assign ctrl       = !busy && (i_pause || i_stop || (back_mode != backward));
    assign step       = running && (i_rd_valid || (!busy && !ctrl && !addr_ok && has_credit));
    assign adv        = prime || i_fast || (phase == i_speed - 1'b1);
    assign push       = ((state == audio_pkg::ST_PAUSE) && has_credit) || (step && !prime);
    assign cur        = addr_ok ? i_rd_data : prev;  // past the end, hold last
    assign o_rd_addr  = addr;
    assign o_playing  = (state != audio_pkg::ST_IDLE);

    always_comb begin
        if (backward)
            nxt = {1'b0, addr} - EXT_W'(i_speed);
        else
            nxt = {1'b0, addr} + (i_fast ? EXT_W'(i_speed) : EXT_W'(1));
        nxt_ok  = backward ? !nxt[EXT_W-1] : (nxt <= {1'b0, i_end_addr});
        lin_sum = frac_mul(prev, i_speed) * (i_speed - phase)
                  + frac_mul(cur, i_speed) * phase;
        out     = (i_fast || !i_interpolation) ? prev : lin_sum[`AUD_SAMPLE_W-1:0];
    end

    always_ff @(posedge i_clk) begin
        if (step && adv)
            prev <= cur;
        if (push)
            o_smp_data <= (state == audio_pkg::ST_PAUSE) ? '0 : out;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= audio_pkg::ST_IDLE;
            addr        <= '0;
            addr_ok     <= 1'b0;
            prime       <= 1'b0;
            phase       <= '0;
            credits     <= CRED_W'(`AUD_DAC_CREDITS);
            o_rd_req    <= 1'b0;
            o_smp_valid <= 1'b0;
        end else begin
            o_smp_valid <= push;
            credits     <= credits + CRED_W'(i_credit) - CRED_W'(push);
            if (i_rd_gnt)
                o_rd_req <= 1'b0;
            case (state)
                audio_pkg::ST_IDLE: begin
                    if (i_start && !i_recording) begin
                        state   <= back_mode ? audio_pkg::ST_BACKTRACK : audio_pkg::ST_PLAY;
                        addr    <= back_mode ? i_end_addr : '0;
                        addr_ok <= 1'b1;
                        prime   <= 1'b1;
                        phase   <= '0;
                    end
                end
                audio_pkg::ST_PAUSE: begin
                    if (i_stop)
                        state <= audio_pkg::ST_IDLE;
                    else if (!i_pause)
                        state <= audio_pkg::ST_PLAY;
                end
                default: begin
                    if (ctrl) begin
                        if (i_pause)
                            state <= audio_pkg::ST_PAUSE;
                        else if (i_stop)
                            state <= audio_pkg::ST_IDLE;
                        else
                            state <= back_mode ? audio_pkg::ST_BACKTRACK : audio_pkg::ST_PLAY;
                    end else if (step) begin
                        if (!adv) begin
                            phase <= phase + 1'b1;
                        end else if (!addr_ok) begin
                            state <= audio_pkg::ST_IDLE;  // last sample sent
                        end else begin
                            phase   <= '0;
                            prime   <= 1'b0;
                            addr    <= nxt[`AUD_ADDR_W-1:0];
                            addr_ok <= nxt_ok;
                        end
                    end else if (!busy && addr_ok && (prime || has_credit)) begin
                        o_rd_req <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credits <= CRED_W'(`AUD_DAC_CREDITS));

    a_speed_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == audio_pkg::ST_IDLE && i_start && !i_recording) |-> (i_speed != '0));

endmodule

/* audio_recorder.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module audio_recorder (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_record,
    input  logic               i_stop,
    input  logic               i_bclk,
    input  logic               i_lrck,
    input  logic               i_adc_dat,
    output logic               o_wr_req,
    output mem_pkg::ram_addr_t o_wr_addr,
    output audio_pkg::sample_t o_wr_data,
    input  logic               i_wr_gnt,
    output mem_pkg::ram_addr_t o_end_addr,
    output logic               o_recording
);

    localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

    logic               bclk_p;
    logic               lrck_p;
    logic               frame_start;
    logic               take_bit;
    logic [CNT_W-1:0]   bit_cnt;  // full count means no frame open
    audio_pkg::sample_t shift;

    assign frame_start = lrck_p && !i_lrck;  // left channel begins
    assign take_bit    = o_recording && !frame_start && i_bclk && !bclk_p
                         && (bit_cnt < CNT_W'(`AUD_SAMPLE_W));

    always_ff @(posedge i_clk) begin
        if (take_bit)
            shift <= {shift[`AUD_SAMPLE_W-2:0], i_adc_dat};
        if (take_bit && (bit_cnt == CNT_W'(`AUD_SAMPLE_W - 1)))
            o_wr_data <= {shift[`AUD_SAMPLE_W-2:0], i_adc_dat};
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bclk_p      <= 1'b0;
            lrck_p      <= 1'b0;
            bit_cnt     <= CNT_W'(`AUD_SAMPLE_W);
            o_wr_req    <= 1'b0;
            o_wr_addr   <= '0;
            o_end_addr  <= '0;
            o_recording <= 1'b0;
        end else begin
            bclk_p <= i_bclk;
            lrck_p <= i_lrck;
            if (!o_recording) begin
                if (i_record) begin
                    o_recording <= 1'b1;
                    o_wr_addr   <= '0;
                    bit_cnt     <= CNT_W'(`AUD_SAMPLE_W);  // wait for a frame edge
                end
            end else if (i_stop) begin
                o_recording <= 1'b0;
            end else if (frame_start) begin
                bit_cnt <= '0;
            end else if (take_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`AUD_SAMPLE_W - 1))
                    o_wr_req <= 1'b1;
            end
            if (o_wr_req && i_wr_gnt) begin
                o_wr_req   <= 1'b0;
                o_end_addr <= o_wr_addr;
                o_wr_addr  <= o_wr_addr + 1'b1;
                if (o_wr_addr == mem_pkg::ram_addr_t'(`AUD_RAM_DEPTH - 1))
                    o_recording <= 1'b0;  // ram full
            end
        end
    end

endmodule

/* dac_serializer.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module dac_serializer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_smp_valid,
    input  audio_pkg::sample_t i_smp_data,
    output logic               o_credit,
    input  logic               i_bclk,
    input  logic               i_lrck,
    output logic               o_dac_dat
);

    localparam int PTR_W = $clog2(`AUD_DAC_CREDITS);
    localparam int CNT_W = $clog2(`AUD_DAC_CREDITS + 1);

    audio_pkg::sample_t buf_mem [`AUD_DAC_CREDITS];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    audio_pkg::sample_t shift;
    audio_pkg::sample_t next_smp;
    logic               bclk_p;
    logic               lrck_p;
    logic               frame_start;
    logic               bclk_fall;
    logic               pop;

    assign frame_start = lrck_p && !i_lrck;
    assign bclk_fall   = bclk_p && !i_bclk;
    assign pop         = frame_start && (count != '0);
    assign next_smp    = pop ? buf_mem[rd_ptr] : '0;  // empty buffer sends silence

    always_ff @(posedge i_clk) begin
        if (i_smp_valid)
            buf_mem[wr_ptr] <= i_smp_data;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            shift     <= '0;
            bclk_p    <= 1'b0;
            lrck_p    <= 1'b0;
            o_credit  <= 1'b0;
            o_dac_dat <= 1'b0;
        end else begin
            bclk_p   <= i_bclk;
            lrck_p   <= i_lrck;
            o_credit <= pop;  // one credit per consumed sample
            if (i_smp_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(i_smp_valid) - CNT_W'(pop);
            if (frame_start) begin
                o_dac_dat <= next_smp[`AUD_SAMPLE_W-1];  // msb right at frame start
                shift     <= next_smp << 1;
            end else if (bclk_fall) begin
                o_dac_dat <= shift[`AUD_SAMPLE_W-1];
                shift     <= shift << 1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_smp_valid |-> (count < CNT_W'(`AUD_DAC_CREDITS)));

endmodule

/* mem_pkg.sv */
`include "audio_defines.svh"

package mem_pkg;

    typedef logic [`AUD_ADDR_W-1:0] ram_addr_t;

    typedef enum logic {
        CL_RECORDER = 1'b0,  // higher priority
        CL_PLAYER   = 1'b1
    } client_e;

endpackage

/* sample_ram_arbiter.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module sample_ram_arbiter (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_wr_req,
    input  mem_pkg::ram_addr_t i_wr_addr,
    input  audio_pkg::sample_t i_wr_data,
    output logic               o_wr_gnt,
    input  logic               i_rd_req,
    input  mem_pkg::ram_addr_t i_rd_addr,
    output logic               o_rd_gnt,
    output logic               o_rd_valid,
    output audio_pkg::sample_t o_rd_data
);

    audio_pkg::sample_t ram [`AUD_RAM_DEPTH];
    mem_pkg::client_e   sel;
    mem_pkg::ram_addr_t ram_addr;

    assign sel      = i_wr_req ? mem_pkg::CL_RECORDER : mem_pkg::CL_PLAYER;
    assign o_wr_gnt = i_wr_req;
    assign o_rd_gnt = i_rd_req && (sel == mem_pkg::CL_PLAYER);
    assign ram_addr = (sel == mem_pkg::CL_RECORDER) ? i_wr_addr : i_rd_addr;  // one port

    always_ff @(posedge i_clk) begin
        if (o_wr_gnt)
            ram[ram_addr] <= i_wr_data;
        else if (o_rd_gnt)
            o_rd_data <= ram[ram_addr];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= o_rd_gnt;  // data one cycle after grant
        end
    end

    a_wr_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wr_gnt |=> !i_wr_req);  // one write per frame

    a_rd_wait_one: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rd_req && !o_rd_gnt) |=> o_rd_gnt);

endmodule

/* src.f */
+incdir+.
audio_pkg.sv
mem_pkg.sv
sample_ram_arbiter.sv
audio_recorder.sv
audio_player.sv
dac_serializer.sv
audio_core_top.sv
tb_audio_core.sv

/* tb_audio_core.sv */
`timescale 1ns/1ns
`include "audio_defines.svh"

module tb_audio_core;

    localparam int N_REC        = 16;
    localparam int FRAME_TICKS  = 256;  // 32 bclk of 8 clocks
    localparam int ZERO_LIMIT   = 8;
    localparam int PAUSE_FRAMES = 4;
    localparam int HDR_WORDS    = 6;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     i_record;
    logic                     i_start;
    logic                     i_pause;
    logic                     i_stop;
    logic                     i_fast;
    logic [`AUD_SPEED_W-1:0]  i_speed;
    logic                     i_interpolation;
    logic                     i_bclk;
    logic                     i_lrck;
    logic                     i_adc_dat;
    logic                     o_dac_dat;
    logic                     o_recording;
    logic                     o_playing;

    logic [`AUD_SAMPLE_W-1:0] tdata [0:255];
    logic [`AUD_SAMPLE_W-1:0] adc_word;  // left sample sent in the current frame
    logic [`AUD_SAMPLE_W-1:0] dac_word;  // left sample seen in the last frame
    int                       tcnt;
    int                       ptr;

    audio_core_top UUT (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_record        (i_record),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_speed         (i_speed),
        .i_interpolation (i_interpolation),
        .i_bclk          (i_bclk),
        .i_lrck          (i_lrck),
        .i_adc_dat       (i_adc_dat),
        .o_dac_dat       (o_dac_dat),
        .o_recording     (o_recording),
        .o_playing       (o_playing)
    );

    always #5 i_clk = ~i_clk;

    task automatic check_value(input logic [15:0] expected, input logic [15:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    // drives one i_clk cycle of the serial streams on the falling edge
    task automatic tick();
        int ph;
        int slot;
        ph   = tcnt % 8;
        slot = (tcnt / 8) % 32;
        @(negedge i_clk);
        i_bclk    = (ph >= 4);
        i_lrck    = (slot >= 16);  // low half is the left channel
        i_adc_dat = (slot < 16) ? adc_word[`AUD_SAMPLE_W-1-slot] : 1'b0;
        if (ph == 4 && slot < 16)
            dac_word = {dac_word[`AUD_SAMPLE_W-2:0], o_dac_dat};  // bclk rising
        tcnt++;
    endtask

    task automatic run_frame();
        tick();
        while (tcnt % FRAME_TICKS != 0)
            tick();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (o_playing && n < 4) begin
            run_frame();
            n++;
        end
        if (o_playing)
            report_timeout("o_playing to fall");
    endtask

    task automatic record_samples();
        int n;
        adc_word = tdata[1];
        i_record = 1'b1;
        tick();
        i_record = 1'b0;
        run_frame();
        check_value(16'd1, {15'd0, o_recording}, "o_recording after i_record");
        for (int f = 1; f < N_REC; f++) begin
            adc_word = tdata[1 + f];
            run_frame();
        end
        i_stop = 1'b1;
        tick();
        i_stop   = 1'b0;
        adc_word = '0;
        run_frame();
        n = 0;
        while (o_recording && n < 4) begin
            run_frame();
            n++;
        end
        if (o_recording)
            report_timeout("o_recording to fall");
    endtask

    task automatic play_case(input int case_no);
        logic [`AUD_SAMPLE_W-1:0] word;
        int                       count;
        int                       pause_after;
        int                       idx;
        int                       zeros;
        int                       pause_frames;
        int                       drain;
        logic                     self_end;
        logic                     paused;
        logic                     gap_seen;
        i_fast          = tdata[ptr][0];
        i_speed         = tdata[ptr + 1][`AUD_SPEED_W-1:0];
        i_interpolation = tdata[ptr + 2][0];
        pause_after     = tdata[ptr + 3];
        self_end        = tdata[ptr + 4][0];
        count           = tdata[ptr + 5];
        ptr             = ptr + HDR_WORDS;
        i_start = 1'b1;
        tick();
        i_start      = 1'b0;
        check_value(16'd1, {15'd0, o_playing}, "o_playing after i_start");
        idx          = 0;
        zeros        = 0;
        pause_frames = 0;
        paused       = 1'b0;
        gap_seen     = 1'b0;
        while (idx < count) begin
            run_frame();
            word = dac_word;
            if (paused && pause_frames < PAUSE_FRAMES) begin
                pause_frames++;
                if (word == '0)
                    gap_seen = 1'b1;
                if (pause_frames == PAUSE_FRAMES)
                    i_pause = 1'b0;  // release
            end
            if (word == '0) begin
                zeros++;  // silence before and around playback
                if (zeros > ZERO_LIMIT)
                    report_timeout("a nonzero dac frame");
            end else begin
                zeros = 0;
                check_value(tdata[ptr + idx], word,
                            $sformatf("case %0d sample %0d", case_no, idx));
                idx++;
                if (idx == pause_after && !paused) begin
                    i_pause = 1'b1;
                    paused  = 1'b1;
                end
            end
        end
        if (pause_after != 0)
            check_value(16'd1, {15'd0, gap_seen}, "zero frames during pause");
        if (self_end) begin
            wait_idle();
            repeat (2) begin
                run_frame();
                check_value('0, dac_word, "silence after the last sample");
            end
        end else begin
            i_stop = 1'b1;
            wait_idle();
            i_stop = 1'b0;
            drain  = 0;
            run_frame();
            while (dac_word != '0 && drain < 4) begin
                run_frame();  // stale samples leave the dac buffer
                drain++;
            end
            if (dac_word != '0)
                report_timeout("the dac buffer to drain");
        end
        ptr = ptr + count;
    endtask

    initial begin
        int n_cases;
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_record        = 1'b0;
        i_start         = 1'b0;
        i_pause         = 1'b0;
        i_stop          = 1'b0;
        i_fast          = 1'b0;
        i_speed         = '0;
        i_interpolation = 1'b0;
        i_bclk          = 1'b0;
        i_lrck          = 1'b0;
        i_adc_dat       = 1'b0;
        adc_word        = '0;
        dac_word        = '0;
        tcnt            = 0;
        $readmemh("testdata_audio.txt", tdata);
        repeat (3) tick();
        i_rst_n = 1'b1;
        run_frame();
        record_samples();
        n_cases = tdata[0];
        ptr     = 1 + N_REC;
        for (int c = 1; c <= n_cases; c++)
            play_case(c);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* testdata_audio.txt */
// hex words: number of cases, then the 16 samples to record, then per case
// fast speed interp pause_after self_end count, followed by count expected dac samples
0006
0C03 1806 2409 300C 3C0F 4812 5415 6018 6C1B 781E 8421 9024 9C27 A82A B42D C030
// normal speed
0000 0001 0000 0000 0001 0010
0C03 1806 2409 300C 3C0F 4812 5415 6018 6C1B 781E 8421 9024 9C27 A82A B42D C030
// fast forward x3
0001 0003 0000 0000 0001 0006
0C03 300C 5415 781E 9C27 C030
// slow x4 constant, stopped early
0000 0004 0000 0000 0000 000C
0C03 0C03 0C03 0C03 1806 1806 1806 1806 2409 2409 2409 2409
// slow x3 linear, stopped early
0000 0003 0001 0000 0000 0009
0C00 1001 1402 1803 1C04 2005 2406 2807 2C08
// backtrack x2 from the end address
0001 0002 0001 0000 0001 0008
C030 A82A 9024 781E 6018 4812 300C 1806
// normal speed, paused after five samples
0000 0001 0000 0005 0001 0010
0C03 1806 2409 300C 3C0F 4812 5415 6018 6C1B 781E 8421 9024 9C27 A82A B42D C030
